// File: tb.f
src/st_audio_pkg.sv
src/st_timing_pkg.sv
src/st_clk_en.sv
src/xsint_delay.sv
src/ym_mix.sv
src/audio_mix.sv
src/sigma_delta_dac.sv
src/st_audio_top.sv
verification/st_audio_chk.sv
verification/st_audio_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the st audio testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module st_audio_tb -f tb.f -o st_audio_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# assertion errors must not stop the run before the closing report
out=$(./obj_dir/st_audio_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^Everything OK$'; then
	exit 0
fi
echo "pass message not found"
exit 1

// File: verification/st_audio_tb.sv
/* st audio testbench: clock, reset, irq and mfp stimulus,
   bitstream density counting against a mix model */
`timescale 1ns/100ps
`default_nettype none

module st_audio_tb;

	import st_audio_pkg::*;
	import st_timing_pkg::*;

	localparam int CLK_PERIOD = 100;	// ns
	localparam int RESET_CYCLES = 5;
	localparam int SETTLE_CYCLES = 8;	// pipeline is 3 deep
	localparam int WINDOW = 1 << MIX_W;	// one full accumulator period
	localparam int IRQ_CYCLES = 400;	// two delay periods plus a pulse
	localparam int TEST_CYCLES = 40_000;	// density window plus margin
	localparam int N_TESTS = 6;

	logic clk_32;
	logic xsint;	// sound irq, resets the dut
	logic ste_i;
	logic psg_stereo_i;
	logic mono_detect_i;
	ym_chan_t ym_a_i, ym_b_i, ym_c_i;
	dma_snd_t dma_snd_l_i, dma_snd_r_i;
	wire audio_l_o, audio_r_o;
	wire xsint_delayed_o, mfp_io7_o;

	integer seed = 32'hf94c_a0e7;
	int density_errs = 0;

	st_audio_top #(
		.CLK_DIV         (CLK2_DIV),
		.XSINT_DELAY_LEN (XSINT_DELAY_LEN),
		.MIX_W           (MIX_W)
	) dut0 (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.ste_i           (ste_i),
		.psg_stereo_i    (psg_stereo_i),
		.mono_detect_i   (mono_detect_i),
		.ym_a_i          (ym_a_i),
		.ym_b_i          (ym_b_i),
		.ym_c_i          (ym_c_i),
		.dma_snd_l_i     (dma_snd_l_i),
		.dma_snd_r_i     (dma_snd_r_i),
		.audio_l_o       (audio_l_o),
		.audio_r_o       (audio_r_o),
		.xsint_delayed_o (xsint_delayed_o),
		.mfp_io7_o       (mfp_io7_o)
	);

	initial begin
		clk_32 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_32 = ~clk_32;
	end

	// all tests together stay well under this
	initial begin
		#(N_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

	function automatic int next_level();
		next_level = $random(seed) & 'hff;	// one byte
	endfunction

	// ones per window = offset-binary value of the mixed sample
	function automatic int expected_ones(input int psg_sum, input int dma);
		int y;
		int d;
		int wide_y;
		int wide_d;
		int mix;
		y = (psg_sum - int'(YM_OFFSET)) & 'h3ff;	// 10 bit two's complement
		d = (dma - int'(DMA_OFFSET)) & 'hff;
		wide_y = ((y >> 9) << 14) | (y << 4) | (y >> 6);	// sign, value, top 4
		wide_d = ((d >> 7) << 14) | (d << 6) | (d >> 2);	// sign, value, top 6
		mix = (wide_y + wide_d) & (WINDOW - 1);
		expected_ones = mix ^ (WINDOW >> 1);	// sign flip to offset binary
	endfunction

	task automatic check_density(input logic stereo, input int a, input int b,
			input int c, input int dl, input int dr);
		int exp_l;
		int exp_r;
		int ones_l;
		int ones_r;
		if (stereo) begin
			exp_l = expected_ones(a + b, dl);	// a+b left
			exp_r = expected_ones(c + b, dr);	// c+b right
		end else begin
			exp_l = expected_ones(a + b + c, dl);
			exp_r = expected_ones(a + b + c, dr);
		end
		ones_l = 0;
		ones_r = 0;
		@(posedge clk_32);
		psg_stereo_i <= stereo;
		ym_a_i <= a[7:0];
		ym_b_i <= b[7:0];
		ym_c_i <= c[7:0];
		dma_snd_l_i <= dl[7:0];
		dma_snd_r_i <= dr[7:0];
		repeat (SETTLE_CYCLES) @(posedge clk_32);
		repeat (WINDOW) begin
			@(negedge clk_32);	// bits stable mid cycle
			if (audio_l_o)
				ones_l++;
			if (audio_r_o)
				ones_r++;
		end
		assert (ones_l == exp_l) else begin
			$display("Mismatch audio_l_o: expected %0h, measured %0h", exp_l, ones_l);
			density_errs++;
		end
		assert (ones_r == exp_r) else begin
			$display("Mismatch audio_r_o: expected %0h, measured %0h", exp_r, ones_r);
			density_errs++;
		end
	endtask

	initial begin
		logic [31:0] r;
		int i;
		int a;
		int b;
		int c;
		int d;
		xsint = 1'b0;
		ste_i = 1'b1;	// ste in reset, the irq term must drop out
		psg_stereo_i = 1'b0;
		mono_detect_i = 1'b0;
		ym_a_i = '0;
		ym_b_i = '0;
		ym_c_i = '0;
		dma_snd_l_i = DMA_OFFSET;	// silence
		dma_snd_r_i = DMA_OFFSET;
		repeat (RESET_CYCLES) @(posedge clk_32);
		xsint <= 1'b1;

		// irq delay and mfp bit 7 with a short low pulse half way
		for (i = 0; i < IRQ_CYCLES; i++) begin
			@(posedge clk_32);
			r = $random(seed);
			ste_i <= r[0];
			mono_detect_i <= r[1];
			xsint <= (i != IRQ_CYCLES / 2) && (i != IRQ_CYCLES / 2 + 1);
		end

		repeat (2) begin	// mono with random levels
			a = next_level();
			b = next_level();
			c = next_level();
			check_density(1'b0, a, b, c, next_level(), next_level());
		end

		// same dma both sides, so only a vs c splits left from right
		repeat (2) begin
			a = next_level();
			b = next_level();
			c = next_level();
			while (c == a) begin
				c = next_level();
			end
			d = next_level();
			check_density(1'b1, a, b, c, d, d);
		end

		// 3 x 0xab sits one above the psg midpoint
		check_density(1'b0, 'hab, 'hab, 'hab, next_level(), next_level());

		repeat (2) @(posedge clk_32);
		$display("density errors %0d, assertion failures %0d",
			density_errs, dut0.chk0.fail_cnt);
		if (density_errs == 0 && dut0.chk0.fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/st_audio_chk.sv
/* bound checks on the sound irq delay line, mfp bit 7
   and the outputs held quiet while xsint is low */
`timescale 1ns/100ps
`default_nettype none

module st_audio_chk (
	input wire clk_32,
	input wire xsint,
	input wire ste_i,
	input wire mono_detect_i,
	input wire audio_l_o,
	input wire audio_r_o,
	input wire xsint_delayed_o,
	input wire mfp_io7_o
);

	import st_timing_pkg::*;

	localparam int DELAY_EDGES = CLK2_DIV * XSINT_DELAY_LEN;	// 16 x 8 = 128 edges

	int fail_cnt = 0;	// read by the testbench at the end
	logic [15:0] rel_cnt;	// edges since release, saturates

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			rel_cnt <= '0;
		end else if (rel_cnt != '1) begin
			rel_cnt <= rel_cnt + 16'd1;
		end
	end

	// irq low doubles as reset
	reset_quiet: assert property (@(posedge clk_32)
			!xsint |-> (!audio_l_o && !audio_r_o && !xsint_delayed_o))
		else begin
			$error("outputs not held low while xsint is low");
			fail_cnt++;
		end

	// low before the 128th edge, high from it on
	delay_level: assert property (@(posedge clk_32) disable iff (!xsint)
			xsint_delayed_o == (rel_cnt >= 16'(DELAY_EDGES)))
		else begin
			$error("delayed interrupt level wrong for the time since release");
			fail_cnt++;
		end

	// ste inverts monitor detect while the dma irq is high
	mfp_bit7: assert property (@(posedge clk_32)
			mfp_io7_o == ((ste_i && xsint) ? !mono_detect_i : mono_detect_i))
		else begin
			$error("mfp bit 7 does not follow mono detect and the sound irq");
			fail_cnt++;
		end

endmodule

// one checker per audio top
bind st_audio_top st_audio_chk chk0 (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.ste_i           (ste_i),
	.mono_detect_i   (mono_detect_i),
	.audio_l_o       (audio_l_o),
	.audio_r_o       (audio_r_o),
	.xsint_delayed_o (xsint_delayed_o),
	.mfp_io7_o       (mfp_io7_o)
);

`default_nettype wire

// File: src/st_audio_top.sv
/* st audio output stage: clock enable, sound irq delay,
   psg and dma mixing and two sigma-delta converters */
`timescale 1ns/100ps
`default_nettype none

module st_audio_top #(
	parameter int CLK_DIV = st_timing_pkg::CLK2_DIV,
	parameter int XSINT_DELAY_LEN = st_timing_pkg::XSINT_DELAY_LEN,
	parameter int MIX_W = st_audio_pkg::MIX_W
) (
	input  wire                      clk_32,
	input  wire                      xsint,	// sound irq, active low reset too
	input  wire                      ste_i,
	input  wire                      psg_stereo_i,
	input  wire                      mono_detect_i,
	input  wire st_audio_pkg::ym_chan_t ym_a_i,
	input  wire st_audio_pkg::ym_chan_t ym_b_i,
	input  wire st_audio_pkg::ym_chan_t ym_c_i,
	input  wire st_audio_pkg::dma_snd_t dma_snd_l_i,
	input  wire st_audio_pkg::dma_snd_t dma_snd_r_i,
	output wire                      audio_l_o,	// bitstream left
	output wire                      audio_r_o,
	output wire                      xsint_delayed_o,	// to mfp timer a
	output wire                      mfp_io7_o
);

	import st_audio_pkg::*;

	wire     clk_2_en;
	ym_sum_t ym_l, ym_r;	// signed psg per side
	mix_t    mix_l, mix_r;

	st_clk_en #(.CLK_DIV(CLK_DIV)) clk_en0 (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.clk_2_en_o (clk_2_en)
	);

	xsint_delay #(.DELAY_LEN(XSINT_DELAY_LEN)) xsint_delay0 (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.clk_2_en_i      (clk_2_en),
		.ste_i           (ste_i),
		.mono_detect_i   (mono_detect_i),
		.xsint_delayed_o (xsint_delayed_o),
		.mfp_io7_o       (mfp_io7_o)
	);

	ym_mix ym_mix0 (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.psg_stereo_i (psg_stereo_i),
		.ym_a_i       (ym_a_i),
		.ym_b_i       (ym_b_i),
		.ym_c_i       (ym_c_i),
		.ym_l_o       (ym_l),
		.ym_r_o       (ym_r)
	);

	audio_mix audio_mix0 (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.ym_l_i      (ym_l),
		.ym_r_i      (ym_r),
		.dma_snd_l_i (dma_snd_l_i),
		.dma_snd_r_i (dma_snd_r_i),
		.mix_l_o     (mix_l),
		.mix_r_o     (mix_r)
	);

	sigma_delta_dac #(.WIDTH(MIX_W)) dac_l (
		.clk_32   (clk_32),
		.xsint    (xsint),
		.sample_i (mix_l),
		.bit_o    (audio_l_o)
	);

	sigma_delta_dac #(.WIDTH(MIX_W)) dac_r (
		.clk_32   (clk_32),
		.xsint    (xsint),
		.sample_i (mix_r),
		.bit_o    (audio_r_o)
	);

endmodule

`default_nettype wire

// File: src/sigma_delta_dac.sv
/* first-order sigma-delta converter, one channel */
`timescale 1ns/100ps
`default_nettype none

module sigma_delta_dac #(
	parameter int WIDTH = 15	// accumulator, same as the mix width
) (
	input  wire                  clk_32,
	input  wire                  xsint,
	input  wire st_audio_pkg::mix_t sample_i,	// signed
	output logic                 bit_o	// pulse density stream
);

	logic [WIDTH-1:0] sample_ob;	// offset binary
	logic [WIDTH-1:0] acc;
	logic [WIDTH:0]   acc_next;	// carry on top

	// flipping the sign bit moves zero to mid scale
	assign sample_ob = sample_i ^ {1'b1, {(WIDTH-1){1'b0}}};
	assign acc_next = {1'b0, acc} + {1'b0, sample_ob};

	// carries over 2^WIDTH cycles add up to the sample value
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc <= '0;
			bit_o <= 1'b0;
		end else begin
			acc <= acc_next[WIDTH-1:0];
			bit_o <= acc_next[WIDTH];	// the overflow is the output bit
		end
	end

endmodule

`default_nettype wire

// File: src/audio_mix.sv
/* psg and ste dma sound widened to the mix width
   and added per side */
`timescale 1ns/100ps
`default_nettype none

module audio_mix (
	input  wire                      clk_32,
	input  wire                      xsint,
	input  wire st_audio_pkg::ym_sum_t  ym_l_i,	// signed psg
	input  wire st_audio_pkg::ym_sum_t  ym_r_i,
	input  wire st_audio_pkg::dma_snd_t dma_snd_l_i,	// unsigned dma sound
	input  wire st_audio_pkg::dma_snd_t dma_snd_r_i,
	output st_audio_pkg::mix_t       mix_l_o,
	output st_audio_pkg::mix_t       mix_r_o
);

	import st_audio_pkg::*;

	dma_snd_t dma_l_s, dma_r_s;	// dma made signed
	mix_t ym_l_x, ym_r_x;
	mix_t dma_l_x, dma_r_x;

	// {sign, value, top bits}: one bit of headroom for the sum
	function automatic mix_t expand_ym(input ym_sum_t v);
		expand_ym = {v[$bits(v)-1], v, v[$bits(v)-1 -: YM_EXT_W]};
	endfunction

	function automatic mix_t expand_dma(input dma_snd_t v);
		expand_dma = {v[$bits(v)-1], v, v[$bits(v)-1 -: DMA_EXT_W]};
	endfunction

	assign dma_l_s = dma_snd_l_i - DMA_OFFSET;	// 0x80 becomes zero
	assign dma_r_s = dma_snd_r_i - DMA_OFFSET;

	assign ym_l_x = expand_ym(ym_l_i);
	assign ym_r_x = expand_ym(ym_r_i);
	assign dma_l_x = expand_dma(dma_l_s);
	assign dma_r_x = expand_dma(dma_r_s);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= ym_l_x + dma_l_x;	// modulo 2^15, no clipping
			mix_r_o <= ym_r_x + dma_r_x;
		end
	end

endmodule

`default_nettype wire

// File: src/ym_mix.sv
/* psg channel summing, mono or stereo, made signed
   around the psg midpoint */
`timescale 1ns/100ps
`default_nettype none

module ym_mix (
	input  wire                      clk_32,
	input  wire                      xsint,
	input  wire                      psg_stereo_i,	// 1: a+b left, c+b right
	input  wire st_audio_pkg::ym_chan_t ym_a_i,
	input  wire st_audio_pkg::ym_chan_t ym_b_i,
	input  wire st_audio_pkg::ym_chan_t ym_c_i,
	output st_audio_pkg::ym_sum_t    ym_l_o,	// signed, two's complement
	output st_audio_pkg::ym_sum_t    ym_r_o
);

	import st_audio_pkg::*;

	ym_sum_t a_w, b_w, c_w;	// channels widened before adding
	ym_sum_t sum_l, sum_r;

	assign a_w = ym_sum_t'(ym_a_i);
	assign b_w = ym_sum_t'(ym_b_i);
	assign c_w = ym_sum_t'(ym_c_i);

	// b sits in the middle, on both sides
	always_comb begin
		if (psg_stereo_i) begin
			sum_l = a_w + b_w;
			sum_r = c_w + b_w;
		end else begin
			sum_l = a_w + b_w + c_w;	// mono: everything on both sides
			sum_r = sum_l;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_l_o <= '0;
			ym_r_o <= '0;
		end else begin
			ym_l_o <= sum_l - YM_OFFSET;	// wraps modulo 2^10
			ym_r_o <= sum_r - YM_OFFSET;
		end
	end

endmodule

`default_nettype wire

// File: src/xsint_delay.sv
/* sound interrupt delay line (74ls164) for mfp timer a
   and the mono-detect input on mfp gpio bit 7 */
`timescale 1ns/100ps
`default_nettype none

module xsint_delay #(
	parameter int DELAY_LEN = 8	// shift stages
) (
	input  wire  clk_32,
	input  wire  xsint,	// sound irq, also clears the chain
	input  wire  clk_2_en_i,	// 2 MHz shift clock
	input  wire  ste_i,
	input  wire  mono_detect_i,
	output logic xsint_delayed_o,	// to timer a input
	output logic mfp_io7_o
);

	logic [DELAY_LEN-1:0] stages;

	// cleared as long as the irq line sits low
	// the chain then fills with the released level
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			stages <= '0;	// async clear, like the '164 MR pin
		end else if (clk_2_en_i) begin
			stages <= {stages[DELAY_LEN-2:0], xsint};
		end
	end

	assign xsint_delayed_o = stages[DELAY_LEN-1];	// last stage

	// ste xors the dma sound irq onto the monitor detect
	assign mfp_io7_o = mono_detect_i ^ (ste_i & xsint);

endmodule

`default_nettype wire

// File: src/st_clk_en.sv
/* 2 MHz clock-enable divider running off clk_32 */
`timescale 1ns/100ps
`default_nettype none

module st_clk_en #(
	parameter int CLK_DIV = 16	// clk_32 cycles per enable
) (
	input  wire  clk_32,
	input  wire  xsint,	// async, active low
	output logic clk_2_en_o	// one cycle wide
);

	localparam int CNT_W = $clog2(CLK_DIV);

	logic [CNT_W-1:0] cnt;	// free running, modulo CLK_DIV

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cnt <= '0;
			clk_2_en_o <= 1'b0;
		end else begin
			cnt <= (cnt == CNT_W'(CLK_DIV - 1)) ? '0 : cnt + 1'b1;
			// enable sits high while cnt holds its wrap value,
			// so users act on the wrapping edge itself
			clk_2_en_o <= (cnt == CNT_W'(CLK_DIV - 2));
		end
	end

endmodule

`default_nettype wire

// File: src/st_timing_pkg.sv
/* clock-enable ratio and sound interrupt delay length */
`default_nettype none

package st_timing_pkg;

	// 32 MHz / 16 = 2 MHz, psg and 74ls164 clock
	localparam int CLK2_DIV = 16;

	// 74ls164 stages, 8 x 500 ns = 4 us
	localparam int XSINT_DELAY_LEN = 8;

endpackage

`default_nettype wire

// File: src/st_audio_pkg.sv
/* audio sample types, midpoint offsets and expansion widths
   for the psg, ste dma sound and the mixed stream */
`default_nettype none

package st_audio_pkg;

	localparam int MIX_W = 15;	// psg + dma sum fed to the dac

	typedef logic [7:0] ym_chan_t;	// one psg channel level
	typedef logic [9:0] ym_sum_t;	// sum of up to three channels
	typedef logic [7:0] dma_snd_t;	// ste dma sample, unsigned with midpoint
	typedef logic [MIX_W-1:0] mix_t;	// signed mix, two's complement

	// midpoints, subtracted to get signed samples
	localparam ym_sum_t YM_OFFSET = 10'h200;
	localparam dma_snd_t DMA_OFFSET = 8'h80;

	// low bits refilled from the top of each value
	// so full scale stays close to full scale
	localparam int YM_EXT_W = 4;	// 1 + 10 + 4 = 15
	localparam int DMA_EXT_W = 6;	// 1 + 8 + 6 = 15

endpackage

`default_nettype wire
